// ==== audio_controller/audio_controller.sv ====
// Audio CPU port and FIFO control
`default_nettype none

`include "audio_defines.svh"

module audio_controller (
	input wire i_clock,
	input wire i_rst_n,
	input wire i_request,
	input wire i_rw,
	input wire [3:0] i_address,
	input wire [`AUDIO_BUS_W-1:0] i_wdata,
	output audio_regs_pkg::bus_word_t o_rdata,
	output logic o_ready,
	output logic o_interrupt,
	audio_sample_if.ctrl snk
);
	localparam int DEPTH = `AUDIO_FIFO_DEPTH;
	localparam int COUNT_W = `AUDIO_COUNT_W;

	audio_regs_pkg::reg_addr_e addr;
	audio_regs_pkg::bus_word_t reload;
	audio_stream_pkg::sample_t fifo_wdata;

	logic is_write;
	logic accept;
	logic fifo_write;
	logic fifo_empty;
	logic fifo_full;
	logic [COUNT_W-1:0] fifo_count;
	logic above_half;
	logic [1:0] half_hist;

	audio_fifo fifo (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_write(fifo_write),
		.i_wdata(fifo_wdata),
		.i_read(snk.take),
		.o_rdata(snk.sample),
		.o_empty(fifo_empty),
		.o_full(fifo_full),
		.o_count(fifo_count)
	);

	assign addr = audio_regs_pkg::reg_addr_e'(i_address);
	assign is_write = (audio_regs_pkg::bus_op_e'(i_rw) == audio_regs_pkg::OP_WRITE);

	// New request not yet answered.
	assign accept = i_request && !o_ready;

	// Hand the head to the output stage as soon as it is free.
	assign snk.take = !snk.busy && !fifo_empty;
	assign snk.reload = reload;

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			o_ready <= 1'b0;
			fifo_write <= 1'b0;
			reload <= `AUDIO_RELOAD_RESET;
		end else begin
			fifo_write <= 1'b0;
			if (accept) begin
				if (is_write) begin
					case (addr)
						audio_regs_pkg::REG_DATA: begin
							// Stall while full, unless a take frees a slot now.
							if (!fifo_full || snk.take) begin
								fifo_write <= 1'b1;
								o_ready <= 1'b1;
							end
						end
						audio_regs_pkg::REG_RELOAD: begin
							reload <= i_wdata;
							o_ready <= 1'b1;
						end
						default: o_ready <= 1'b1;
					endcase
				end else begin
					o_ready <= 1'b1;
				end
			end else if (!i_request) begin
				o_ready <= 1'b0;
			end
		end
	end

	// Read data and the sample to push.
	always_ff @(posedge i_clock) begin
		if (accept) begin
			fifo_wdata <= audio_stream_pkg::sample_t'(i_wdata);
			case (addr)
				audio_regs_pkg::REG_DATA: o_rdata <= audio_regs_pkg::bus_word_t'(fifo_count);
				audio_regs_pkg::REG_RELOAD: o_rdata <= reload;
				default: o_rdata <= '0;
			endcase
		end
	end

	// Refill request when the fill drops to half or below.
	assign above_half = (fifo_count > COUNT_W'(DEPTH / 2));

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			half_hist <= 2'b00;
			o_interrupt <= 1'b0;
		end else begin
			half_hist <= {half_hist[0], above_half};
			o_interrupt <= (half_hist == 2'b10);
		end
	end

endmodule

`default_nettype wire

// ==== audio_fifo/audio_fifo.sv ====
// Block RAM sample FIFO
`default_nettype none

`include "audio_defines.svh"

module audio_fifo (
	input wire i_clock,
	input wire i_rst_n,
	input wire i_write,
	input wire audio_stream_pkg::sample_t i_wdata,
	input wire i_read,
	output audio_stream_pkg::sample_t o_rdata,
	output logic o_empty,
	output logic o_full,
	output logic [`AUDIO_COUNT_W-1:0] o_count
);
	localparam int DEPTH = `AUDIO_FIFO_DEPTH;
	localparam int ADDR_W = $clog2(DEPTH);
	localparam int COUNT_W = `AUDIO_COUNT_W;

	audio_stream_pkg::sample_t mem [DEPTH];

	logic [ADDR_W-1:0] wr_ptr;
	logic [ADDR_W-1:0] rd_ptr;
	logic [ADDR_W-1:0] rd_next;
	logic do_write;
	logic do_read;

	assign o_empty = (o_count == '0);
	assign o_full = (o_count == COUNT_W'(DEPTH));

	// A full FIFO still accepts a write in the cycle it is read.
	assign do_read = i_read && !o_empty;
	assign do_write = i_write && (!o_full || do_read);

	// Address of the word that becomes the head after this edge.
	assign rd_next = do_read ? rd_ptr + 1'b1 : rd_ptr;

	always_ff @(posedge i_clock) begin
		if (do_write) begin
			mem[wr_ptr] <= i_wdata;
		end
	end

	// Registered head word.
	// A write into the next head slot bypasses the RAM.
	always_ff @(posedge i_clock) begin
		if (do_write && (wr_ptr == rd_next)) begin
			o_rdata <= i_wdata;
		end else begin
			o_rdata <= mem[rd_next];
		end
	end

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			o_count <= '0;
		end else begin
			rd_ptr <= rd_next;
			if (do_write) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			// Read plus write leaves the count alone.
			case ({do_write, do_read})
				2'b10: o_count <= o_count + 1'b1;
				2'b01: o_count <= o_count - 1'b1;
				default: o_count <= o_count;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== audio_output/audio_output.sv ====
// Paced DAC output stage
`default_nettype none

`include "audio_defines.svh"

module audio_output (
	input wire i_clock,
	input wire i_rst_n,
	audio_sample_if.out_stage src,
	output audio_stream_pkg::channel_t o_dac_left,
	output audio_stream_pkg::channel_t o_dac_right,
	output logic o_dac_strobe
);
	audio_stream_pkg::out_state_e state;

	logic [`AUDIO_BUS_W-1:0] period;
	logic [`AUDIO_BUS_W-1:0] hold_count;

	// Periods below two cycles are clamped.
	assign period = (src.reload < `AUDIO_BUS_W'(2)) ? `AUDIO_BUS_W'(2) : src.reload;

	// Busy covers the period minus the take cycle.
	assign src.busy = (state == audio_stream_pkg::OUT_HOLD);

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			state <= audio_stream_pkg::OUT_IDLE;
			hold_count <= '0;
		end else begin
			case (state)
				audio_stream_pkg::OUT_IDLE: begin
					if (src.take) begin
						state <= audio_stream_pkg::OUT_HOLD;
						hold_count <= period - `AUDIO_BUS_W'(2);
					end
				end
				audio_stream_pkg::OUT_HOLD: begin
					if (hold_count == '0) begin
						state <= audio_stream_pkg::OUT_IDLE;
					end else begin
						hold_count <= hold_count - 1'b1;
					end
				end
				default: state <= audio_stream_pkg::OUT_IDLE;
			endcase
		end
	end

	// DAC registers, strobed one cycle after the take.
	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			o_dac_left <= '0;
			o_dac_right <= '0;
			o_dac_strobe <= 1'b0;
		end else begin
			o_dac_strobe <= src.take;
			if (src.take) begin
				o_dac_left <= src.sample.left;
				o_dac_right <= src.sample.right;
			end
		end
	end

endmodule

`default_nettype wire

// ==== audio_top.f ====
+incdir+common
common/audio_regs_pkg.sv
common/audio_stream_pkg.sv
common/audio_sample_if.sv
audio_fifo/audio_fifo.sv
audio_controller/audio_controller.sv
audio_output/audio_output.sv
verilog/audio_top.sv
verif/audio_top_assert.sv
verif/audio_top_tb.sv

// ==== common/audio_defines.svh ====
// Audio subsystem parameters
`ifndef AUDIO_DEFINES_SVH
`define AUDIO_DEFINES_SVH

// Number of sample FIFO entries, a power of two.
`define AUDIO_FIFO_DEPTH 64

// Fill count width, wide enough to hold a full FIFO.
`define AUDIO_COUNT_W ($clog2(`AUDIO_FIFO_DEPTH) + 1)

// Pacing period after reset, in clock cycles.
`define AUDIO_RELOAD_RESET 4536

// Packed stereo sample width.
`define AUDIO_SAMPLE_W 32

// CPU data bus width.
`define AUDIO_BUS_W 32

`endif

// ==== common/audio_regs_pkg.sv ====
// Audio CPU register map
`default_nettype none

`include "audio_defines.svh"

package audio_regs_pkg;

	// One CPU data word.
	typedef logic [`AUDIO_BUS_W-1:0] bus_word_t;

	// Register addresses on the 4-bit address bus.
	// Data writes push a sample, data reads return the fill count.
	typedef enum logic [3:0] {
		REG_DATA   = 4'h0,
		REG_RELOAD = 4'h1
	} reg_addr_e;

	// Meaning of the rw input.
	typedef enum logic {
		OP_READ  = 1'b0,
		OP_WRITE = 1'b1
	} bus_op_e;

endpackage

`default_nettype wire

// ==== common/audio_sample_if.sv ====
// Controller to output stage link
`default_nettype none

`include "audio_defines.svh"

interface audio_sample_if;

	// FIFO head, valid while take is high.
	audio_stream_pkg::sample_t sample;
	// One-cycle pulse when a sample leaves the FIFO.
	logic take;
	// Output stage is pacing the previous sample.
	logic busy;
	// Pacing period held in the controller.
	logic [`AUDIO_BUS_W-1:0] reload;

	modport ctrl (
		output sample,
		output take,
		output reload,
		input busy
	);

	modport out_stage (
		input sample,
		input take,
		input reload,
		output busy
	);

endinterface

`default_nettype wire

// ==== common/audio_stream_pkg.sv ====
// Audio sample stream types
`default_nettype none

`include "audio_defines.svh"

package audio_stream_pkg;

	// One audio channel.
	typedef logic [`AUDIO_SAMPLE_W/2-1:0] channel_t;

	// Stereo pair, left in the upper half.
	typedef struct packed {
		channel_t left;
		channel_t right;
	} sample_t;

	// Output stage pacing states.
	typedef enum logic {
		OUT_IDLE = 1'b0,
		OUT_HOLD = 1'b1
	} out_state_e;

endpackage

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the audio playback simulation with Verilator.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=audio_top_sim
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module audio_top_tb \
	-f audio_top.f \
	-Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
	echo "Build failed"
	exit 1
fi

./"$BUILD_DIR"/"$SIM_BIN" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "CHECKS FAILED" "$LOG"; then
	echo "Simulation failed"
	exit 1
fi

echo "Simulation passed"
exit 0

// ==== verif/audio_top_assert.sv ====
// Audio playback checker
`default_nettype none

`include "audio_defines.svh"

module audio_top_assert (
	input wire i_clock,
	input wire i_rst_n,
	input wire i_request,
	input wire i_rw,
	input wire [3:0] i_address,
	input wire [`AUDIO_BUS_W-1:0] i_wdata,
	input wire i_ready,
	input wire i_interrupt,
	input wire [`AUDIO_SAMPLE_W/2-1:0] i_dac_left,
	input wire [`AUDIO_SAMPLE_W/2-1:0] i_dac_right,
	input wire i_dac_strobe
);
	timeunit 1ns;
	timeprecision 1ps;

	audio_stream_pkg::sample_t sent_q [$];
	audio_stream_pkg::sample_t head;
	logic head_valid;
	logic ready_q;
	logic ack;
	logic above_q;
	logic [3:0] pend_addr;
	logic pend_write;
	logic [`AUDIO_BUS_W-1:0] pend_data;
	logic [`AUDIO_BUS_W-1:0] reload_val;
	logic [`AUDIO_BUS_W-1:0] gap_period;
	logic gap_armed;
	int unsigned gap_count;
	int unsigned req_wait;
	int fail_count = 0;

	// First cycle of ready for the pending request.
	assign ack = i_ready && !ready_q;

	always @(posedge i_clock) begin
		if (!i_rst_n) begin
			sent_q.delete();
			ready_q <= 1'b0;
			above_q <= 1'b0;
			pend_addr <= '0;
			pend_write <= 1'b0;
			pend_data <= '0;
			reload_val <= `AUDIO_RELOAD_RESET;
			gap_armed <= 1'b0;
			gap_count <= 0;
			gap_period <= 2;
			req_wait <= 0;
		end else begin
			ready_q <= i_ready;
			// The CPU holds its inputs while the request waits.
			if (i_request && !i_ready) begin
				pend_addr <= i_address;
				pend_write <= (audio_regs_pkg::bus_op_e'(i_rw) == audio_regs_pkg::OP_WRITE);
				pend_data <= i_wdata;
				req_wait <= req_wait + 1;
			end else begin
				req_wait <= 0;
			end
			// Next gap is only defined when another sample was already queued.
			if (i_dac_strobe) begin
				gap_armed <= (sent_q.size() >= 2);
				gap_period <= reload_val;
				gap_count <= 1;
				if (sent_q.size() > 0) begin
					void'(sent_q.pop_front());
				end
			end else begin
				gap_count <= gap_count + 1;
			end
			if (ack && pend_write) begin
				if (pend_addr == audio_regs_pkg::REG_DATA) begin
					sent_q.push_back(audio_stream_pkg::sample_t'(pend_data));
				end else if (pend_addr == audio_regs_pkg::REG_RELOAD) begin
					reload_val <= (pend_data < 2) ? `AUDIO_BUS_W'(2) : pend_data;
				end
			end
			// Model fill above half, one cycle behind the FIFO on reads.
			above_q <= (sent_q.size() > `AUDIO_FIFO_DEPTH / 2);
		end
		head_valid <= (sent_q.size() != 0);
		head <= (sent_q.size() != 0) ? sent_q[0] : '0;
	end

	a_sample_order: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		i_dac_strobe |-> head_valid && ({i_dac_left, i_dac_right} == head))
	else begin
		$error("Fail at %0t: DAC pair differs from the oldest written sample", $time);
		fail_count++;
	end

	a_strobe_gap: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		i_dac_strobe && gap_armed |-> gap_count == gap_period)
	else begin
		$error("Fail at %0t: strobe spacing %0d, expected %0d", $time, gap_count, gap_period);
		fail_count++;
	end

	a_stall_release: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		$rose(i_ready) && (req_wait > 1) |-> i_dac_strobe)
	else begin
		$error("Fail at %0t: stalled write completed without a strobe", $time);
		fail_count++;
	end

	a_irq_pulse: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		$fell(above_q) |=> i_interrupt ##1 !i_interrupt)
	else begin
		$error("Fail at %0t: no single-cycle interrupt after the fill fell to half", $time);
		fail_count++;
	end

	a_ready_release: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		i_ready && !i_request |=> !i_ready)
	else begin
		$error("Fail at %0t: ready held after the request dropped", $time);
		fail_count++;
	end

endmodule

`default_nettype wire

// ==== verif/audio_top_tb.sv ====
// Audio playback testbench
`default_nettype none

`include "audio_defines.svh"

module audio_top_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_SAMPLES = 132;
	localparam int MAX_RELOAD = 1000;
	localparam int MARGIN = 20000;
	localparam int BUS_LIMIT = 2 * MAX_RELOAD + 16;

	logic i_clock = 1'b0;
	logic i_rst_n;
	logic i_request;
	logic i_rw;
	logic [3:0] i_address;
	logic [`AUDIO_BUS_W-1:0] i_wdata;
	logic [`AUDIO_BUS_W-1:0] o_rdata;
	logic o_ready;
	logic o_interrupt;
	logic [`AUDIO_SAMPLE_W/2-1:0] o_dac_left;
	logic [`AUDIO_SAMPLE_W/2-1:0] o_dac_right;
	logic o_dac_strobe;

	logic [31:0] rng_state = 32'hb82d272c;
	int acked_writes = 0;
	int strobe_count = 0;
	int irq_count = 0;
	int bus_errors = 0;
	int value_errors = 0;

	audio_top uut (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_request(i_request),
		.i_rw(i_rw),
		.i_address(i_address),
		.i_wdata(i_wdata),
		.o_rdata(o_rdata),
		.o_ready(o_ready),
		.o_interrupt(o_interrupt),
		.o_dac_left(o_dac_left),
		.o_dac_right(o_dac_right),
		.o_dac_strobe(o_dac_strobe)
	);

	bind audio_top audio_top_assert checks (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_request(i_request),
		.i_rw(i_rw),
		.i_address(i_address),
		.i_wdata(i_wdata),
		.i_ready(o_ready),
		.i_interrupt(o_interrupt),
		.i_dac_left(o_dac_left),
		.i_dac_right(o_dac_right),
		.i_dac_strobe(o_dac_strobe)
	);

	initial begin
		forever #20 i_clock = ~i_clock;
	end

	// Strobes and interrupts seen so far.
	always @(posedge i_clock) begin
		if (o_dac_strobe) begin
			strobe_count++;
		end
		if (o_interrupt) begin
			irq_count++;
		end
	end

	function automatic logic [31:0] next_random();
		rng_state ^= rng_state << 13;
		rng_state ^= rng_state >> 17;
		rng_state ^= rng_state << 5;
		return rng_state;
	endfunction

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected) begin
			$display("Fail at %0t: %s is %0d, expected %0d", $time, what, got, expected);
			value_errors++;
		end
	endtask

	task automatic wait_ready_low();
		int cycles;
		cycles = 0;
		while (o_ready && cycles < BUS_LIMIT) begin
			@(negedge i_clock);
			cycles++;
		end
		if (o_ready) begin
			$display("Bus timeout: ready stayed high after the request dropped");
			bus_errors++;
		end
	endtask

	// Waited is the number of falling edges until ready was seen.
	task automatic write_reg(input logic [3:0] addr, input logic [31:0] data, output int waited);
		waited = 0;
		i_request = 1'b1;
		i_rw = audio_regs_pkg::OP_WRITE;
		i_address = addr;
		i_wdata = data;
		while (!o_ready && waited < BUS_LIMIT) begin
			@(negedge i_clock);
			waited++;
		end
		if (!o_ready) begin
			$display("Bus timeout: write to address %0d was never acknowledged", addr);
			bus_errors++;
		end else if (addr == audio_regs_pkg::REG_DATA) begin
			acked_writes++;
		end
		i_request = 1'b0;
		wait_ready_low();
	endtask

	task automatic read_reg(input logic [3:0] addr, output logic [31:0] data);
		int waited;
		waited = 0;
		i_request = 1'b1;
		i_rw = audio_regs_pkg::OP_READ;
		i_address = addr;
		while (!o_ready && waited < BUS_LIMIT) begin
			@(negedge i_clock);
			waited++;
		end
		if (!o_ready) begin
			$display("Bus timeout: read of address %0d was never acknowledged", addr);
			bus_errors++;
		end
		data = o_rdata;
		i_request = 1'b0;
		wait_ready_low();
	endtask

	// Fill is acknowledged writes minus strobes, including one being raised now.
	task automatic check_fill();
		logic [31:0] expected;
		logic [31:0] got;
		expected = acked_writes - strobe_count - 32'(o_dac_strobe);
		read_reg(audio_regs_pkg::REG_DATA, got);
		check_value("fill count", got, expected);
	endtask

	task automatic send_samples(input int n);
		int waited;
		repeat (n) begin
			write_reg(audio_regs_pkg::REG_DATA, next_random(), waited);
		end
	endtask

	task automatic wait_drain();
		while (strobe_count != acked_writes) begin
			@(negedge i_clock);
		end
	endtask

	// A long first period lets a backlog build before the target period applies.
	task automatic run_burst(input int period);
		int waited;
		write_reg(audio_regs_pkg::REG_RELOAD, 60, waited);
		send_samples(12);
		check_fill();
		write_reg(audio_regs_pkg::REG_RELOAD, period, waited);
		wait_drain();
		check_fill();
	endtask

	initial begin
		logic [31:0] data;
		int waited;
		i_rst_n = 1'b0;
		i_request = 1'b0;
		i_rw = 1'b0;
		i_address = '0;
		i_wdata = '0;
		repeat (16) @(negedge i_clock);
		i_rst_n = 1'b1;
		@(negedge i_clock);

		// Register access.
		read_reg(audio_regs_pkg::REG_RELOAD, data);
		check_value("reload after reset", data, `AUDIO_RELOAD_RESET);
		write_reg(audio_regs_pkg::REG_RELOAD, 123, waited);
		read_reg(audio_regs_pkg::REG_RELOAD, data);
		check_value("reload readback", data, 123);
		read_reg(4'h5, data);
		check_value("unknown address read", data, 0);
		write_reg(4'h7, 32'hdeadbeef, waited);
		check_value("unknown address write latency", waited, 1);
		read_reg(audio_regs_pkg::REG_RELOAD, data);
		check_value("reload after ignored write", data, 123);
		check_fill();

		// Paced streams at short periods.
		run_burst(2);
		run_burst(5);
		check_value("interrupts after short bursts", irq_count, 0);

		// Fill to full, then stall on further writes.
		write_reg(audio_regs_pkg::REG_RELOAD, MAX_RELOAD, waited);
		for (int i = 0; i < 65; i++) begin
			write_reg(audio_regs_pkg::REG_DATA, next_random(), waited);
			check_value("write latency below full", waited, 1);
		end
		check_fill();
		repeat (3) begin
			write_reg(audio_regs_pkg::REG_DATA, next_random(), waited);
			if (waited <= 1) begin
				$display("Fail at %0t: write to a full FIFO completed without waiting", $time);
				value_errors++;
			end
		end
		wait_drain();
		check_fill();
		check_value("interrupts after first drain", irq_count, 1);

		// Refill past half and drain again.
		write_reg(audio_regs_pkg::REG_RELOAD, 100, waited);
		send_samples(40);
		wait_drain();
		check_fill();
		check_value("interrupts after second drain", irq_count, 2);

		$display("Summary: %0d bus errors, %0d value errors, %0d assertion failures",
			bus_errors, value_errors, uut.checks.fail_count);
		if (bus_errors + value_errors + uut.checks.fail_count == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

	// Every sample may wait one full period at the longest reload.
	initial begin
		repeat (NUM_SAMPLES * MAX_RELOAD + MARGIN) @(posedge i_clock);
		$display("Timeout: the run did not finish within %0d clock cycles",
			NUM_SAMPLES * MAX_RELOAD + MARGIN);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/audio_top.sv ====
// Audio playback top level
`default_nettype none

`include "audio_defines.svh"

module audio_top (
	input wire i_clock,
	input wire i_rst_n,

	// CPU port.
	input wire i_request,
	input wire i_rw,
	input wire [3:0] i_address,
	input wire [`AUDIO_BUS_W-1:0] i_wdata,
	output logic [`AUDIO_BUS_W-1:0] o_rdata,
	output logic o_ready,
	output logic o_interrupt,

	// DAC side.
	output logic [`AUDIO_SAMPLE_W/2-1:0] o_dac_left,
	output logic [`AUDIO_SAMPLE_W/2-1:0] o_dac_right,
	output logic o_dac_strobe
);
	audio_sample_if sample_if ();

	audio_controller controller (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_request(i_request),
		.i_rw(i_rw),
		.i_address(i_address),
		.i_wdata(i_wdata),
		.o_rdata(o_rdata),
		.o_ready(o_ready),
		.o_interrupt(o_interrupt),
		.snk(sample_if.ctrl)
	);

	audio_output out_stage (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.src(sample_if.out_stage),
		.o_dac_left(o_dac_left),
		.o_dac_right(o_dac_right),
		.o_dac_strobe(o_dac_strobe)
	);

endmodule

`default_nettype wire
